/* tb/bpu_trace.txt */
# ir_if pc_if pc4_if | ir_ex pc_ex jump_addr wrong | csr_we csr_addr csr_wdata
# | chk exp_u_jump exp_addr_prediction exp_csr_rdata   (all hex, one record per cycle)
# Reset defaults and non-control lookups
3 00000040 00000044 0 00000000 00000000 0 0 1 00000000 1 0 00000044 00000000
1 00000080 00000084 0 00000000 00000000 0 0 0 00000000 1 0 00000084 00000001
0 00000100 00000104 0 00000000 00000000 0 0 3 00000000 1 0 00000104 00000000
2 0000007c 00000080 0 00000000 00000000 0 0 1 00000000 1 0 00000080 00000002
# State walk at pc 0x40
3 00000040 00000044 3 00000040 00000200 1 0 2 00000000 1 0 00000044 00000000
3 00000040 00000044 3 00000040 00000200 0 0 2 00000000 1 1 00000200 00000001
3 00000040 00000044 3 00000040 00000240 1 0 1 00000000 1 1 00000200 00000005
3 00000040 00000044 3 00000040 00000240 1 0 2 00000000 1 1 00000240 00000002
3 00000040 00000044 3 00000040 00000240 0 0 0 00000000 1 0 00000044 00000001
3 00000040 00000044 3 00000040 00000280 1 0 2 00000000 1 0 00000044 00000003
3 00000040 00000044 3 00000040 00000280 1 0 1 00000000 1 0 00000044 00000009
3 00000040 00000044 0 00000000 00000000 0 0 1 00000000 1 1 00000280 0000000a
# Aliasing of 0xc0 onto 0x40 and same-cycle update
1 000000c0 000000c4 3 000000c0 00000300 0 0 2 00000000 1 1 00000280 00000005
3 00000040 00000044 0 00000000 00000000 0 0 1 00000000 1 1 00000300 0000000c
2 000000c0 000000c4 2 00000040 00000340 1 0 3 00000000 1 1 00000300 00000000
3 00000040 00000044 3 00000040 00000340 1 0 2 00000000 1 1 00000340 00000006
3 000000c0 000000c4 0 00000000 00000000 0 0 1 00000000 1 0 000000c4 0000000f
0 00000080 00000084 1 00000080 00000500 1 0 2 00000000 1 0 00000084 00000007
1 00000080 00000084 1 00000080 00000500 0 0 1 00000000 1 1 00000500 00000010
# Prediction disabled while training continues
1 00000080 00000084 0 00000000 00000000 0 1 0 00000000 1 1 00000500 00000001
1 00000080 00000084 3 00000040 00000600 1 0 0 00000000 1 0 00000084 00000000
3 00000040 00000044 3 00000040 00000600 0 0 1 00000000 1 0 00000044 00000012
3 00000040 00000044 0 00000000 00000000 0 1 0 00000001 1 0 00000044 00000000
3 00000040 00000044 0 00000000 00000000 0 0 0 00000000 1 1 00000600 00000001
1 00000080 00000084 0 00000000 00000000 0 0 1 00000000 1 1 00000500 00000013
# Flush overrides the update in its cycle
0 00000100 00000104 0 00000000 00000000 0 1 0 00000003 1 0 00000104 00000001
3 00000040 00000044 3 00000040 00000700 1 0 0 00000000 1 1 00000600 00000001
3 00000040 00000044 3 00000040 00000720 1 0 2 00000000 1 0 00000044 0000000a
3 00000040 00000044 0 00000000 00000000 0 0 1 00000000 1 1 00000720 00000016
1 00000080 00000084 0 00000000 00000000 0 0 0 00000000 1 0 00000084 00000001
# Counter clears, clear beats a same-cycle event
0 00000100 00000104 0 00000000 00000000 0 1 1 00000000 1 0 00000104 00000018
3 00000040 00000044 0 00000000 00000000 0 0 1 00000000 1 1 00000720 00000000
3 00000040 00000044 0 00000000 00000000 0 1 1 ffffffff 1 1 00000720 00000001
0 00000100 00000104 3 00000100 00000800 1 0 1 00000000 1 0 00000104 00000000
1 00000100 00000104 3 00000100 00000800 1 1 2 00000000 1 1 00000800 0000000c
1 00000080 00000084 0 00000000 00000000 0 0 2 00000000 1 0 00000084 00000000
0 00000000 00000004 0 00000000 00000000 0 0 1 00000000 1 0 00000004 00000002
# Flush with enable off, second flush write absorbed by the pulse
3 00000040 00000044 0 00000000 00000000 0 1 0 00000002 1 1 00000720 00000001
3 00000040 00000044 0 00000000 00000000 0 1 0 00000003 1 0 00000044 00000000
3 00000040 00000044 0 00000000 00000000 0 0 0 00000000 1 0 00000044 00000001
0 00000000 00000004 0 00000000 00000000 0 0 1 00000000 1 0 00000004 00000004

/* filelist.f */
rtl/bpu_pkg.sv
rtl/jump_predictor.sv
rtl/bpu_csr.sv
rtl/bpu_top.sv
tb/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - files:
      - rtl/bpu_pkg.sv
      - rtl/jump_predictor.sv
      - rtl/bpu_csr.sv
      - rtl/bpu_top.sv
  - target: test
    files:
      - tb/bpu_tb.sv

/* tb/bpu_tb.sv */
`default_nettype none

module bpu_tb
    import bpu_pkg::*;
();

    localparam int    CLK_PERIOD     = 4;
    localparam int    CHECK_DELAY    = 3;
    localparam int    RESET_CYCLES   = 3;
    localparam int    TIMEOUT_MARGIN = 20;
    localparam int    NUM_FIELDS     = 14;
    localparam string TRACE_FILE     = "tb/bpu_trace.txt";

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          pc_in_if;
    logic [31:0]          pc4_in_if;
    logic [IR_TYPE_W-1:0] ir_type_in_if;
    logic [31:0]          pc_in_ex;
    logic [IR_TYPE_W-1:0] ir_type_in_ex;
    logic [31:0]          jump_addr_if_taken;
    logic                 is_prediction_wrong;
    logic                 csr_we;
    logic [1:0]           csr_addr;
    logic [31:0]          csr_wdata;
    wire                  u_jump;
    wire  [31:0]          addr_prediction;
    wire  [31:0]          csr_rdata;

    // Expected values of the record in flight
    logic                 exp_chk;
    logic                 exp_u_jump;
    logic [31:0]          exp_addr;
    logic [31:0]          exp_rdata;

    // Reference model of the predictor and its register block
    logic [1:0]           model_state  [TABLE_SIZE];
    logic [31:0]          model_target [TABLE_SIZE];
    logic                 model_enable;
    logic                 model_flush;
    logic [31:0]          model_lookups;
    logic [31:0]          model_mispredicts;

    string                trace_lines[$];
    int                   value_errors  = 0;
    int                   trace_errors  = 0;
    int                   format_errors = 0;
    int                   cycle_count   = 0;
    int                   cycle_limit   = 0;

    bpu_top u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pc_in_if            (pc_in_if),
        .pc4_in_if           (pc4_in_if),
        .ir_type_in_if       (ir_type_in_if),
        .u_jump              (u_jump),
        .addr_prediction     (addr_prediction),
        .pc_in_ex            (pc_in_ex),
        .ir_type_in_ex       (ir_type_in_ex),
        .jump_addr_if_taken  (jump_addr_if_taken),
        .is_prediction_wrong (is_prediction_wrong),
        .csr_we              (csr_we),
        .csr_addr            (csr_addr),
        .csr_wdata           (csr_wdata),
        .csr_rdata           (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit follows the number of trace records
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic is_control(input logic [IR_TYPE_W-1:0] ir_type);
        case (ir_type)
            JAL_IR, JALR_IR, BRANCH_IR: return 1'b1;
            default:                    return 1'b0;
        endcase
    endfunction

    // Full transition table of the 2-bit counter
    function automatic logic [1:0] resolve_state(input logic [1:0] cur, input logic wrong);
        case ({wrong, cur})
            {1'b0, STRONG_DONT_TAKE}: return STRONG_DONT_TAKE;
            {1'b0, WEAK_DONT_TAKE}:   return STRONG_DONT_TAKE;
            {1'b0, WEAK_TAKE}:        return STRONG_TAKE;
            {1'b0, STRONG_TAKE}:      return STRONG_TAKE;
            {1'b1, STRONG_DONT_TAKE}: return WEAK_DONT_TAKE;
            {1'b1, WEAK_DONT_TAKE}:   return WEAK_TAKE;
            {1'b1, WEAK_TAKE}:        return WEAK_DONT_TAKE;
            default:                  return WEAK_TAKE;
        endcase
    endfunction

    function automatic logic model_jump();
        logic [1:0] st;
        st = model_state[pc_in_if[NUM_BITS+1:2]];
        return model_enable && is_control(ir_type_in_if) &&
               (st == WEAK_TAKE || st == STRONG_TAKE);
    endfunction

    function automatic logic [31:0] model_read();
        case (csr_addr)
            CSR_CTRL:        return {31'd0, model_enable};
            CSR_LOOKUPS:     return model_lookups;
            CSR_MISPREDICTS: return model_mispredicts;
            default:         return 32'd0;
        endcase
    endfunction

    task automatic model_reset();
        for (int i = 0; i < TABLE_SIZE; i++) begin
            model_state[i] = WEAK_DONT_TAKE;
        end
        model_enable      = 1'b1;
        model_flush       = 1'b0;
        model_lookups     = 32'd0;
        model_mispredicts = 32'd0;
    endtask

    // Effect of the current inputs at the coming rising edge
    task automatic model_step();
        int   idx;
        logic wr_ctrl;
        logic lookup_event;
        logic mispredict_event;
        logic flush_next;
        idx              = pc_in_ex[NUM_BITS+1:2];
        wr_ctrl          = csr_we && (csr_addr == CSR_CTRL);
        lookup_event     = model_enable && is_control(ir_type_in_if);
        mispredict_event = is_control(ir_type_in_ex) && is_prediction_wrong;
        flush_next       = wr_ctrl && csr_wdata[CTRL_FLUSH_BIT] && !model_flush;
        if (model_flush) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                model_state[i] = WEAK_DONT_TAKE;
            end
        end else if (is_control(ir_type_in_ex)) begin
            model_state[idx]  = resolve_state(model_state[idx], is_prediction_wrong);
            model_target[idx] = jump_addr_if_taken;
        end
        if (csr_we && (csr_addr == CSR_LOOKUPS)) begin
            model_lookups = 32'd0;
        end else if (lookup_event) begin
            model_lookups = model_lookups + 32'd1;
        end
        if (csr_we && (csr_addr == CSR_MISPREDICTS)) begin
            model_mispredicts = 32'd0;
        end else if (mispredict_event) begin
            model_mispredicts = model_mispredicts + 32'd1;
        end
        if (wr_ctrl) begin
            model_enable = csr_wdata[CTRL_ENABLE_BIT];
        end
        model_flush = flush_next;
    endtask

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                trace_lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_record(input string line, input int rec);
        logic [31:0] f [NUM_FIELDS];
        int          n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                    f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (n != NUM_FIELDS) begin
            $display("Trace record %0d has %0d fields instead of %0d", rec, n, NUM_FIELDS);
            format_errors++;
        end
        ir_type_in_if       <= f[0][IR_TYPE_W-1:0];
        pc_in_if            <= f[1];
        pc4_in_if           <= f[2];
        ir_type_in_ex       <= f[3][IR_TYPE_W-1:0];
        pc_in_ex            <= f[4];
        jump_addr_if_taken  <= f[5];
        is_prediction_wrong <= f[6][0];
        csr_we              <= f[7][0];
        csr_addr            <= f[8][1:0];
        csr_wdata           <= f[9];
        exp_chk             <= f[10][0];
        exp_u_jump          <= f[11][0];
        exp_addr            <= f[12];
        exp_rdata           <= f[13];
    endtask

    task automatic check_u_jump(input logic actual, input logic expected, input int rec);
        if (actual !== expected) begin
            $display("ERROR at %0t: record %0d u_jump is %0b, expected %0b",
                     $time, rec, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_addr(input logic [31:0] actual, input logic [31:0] expected,
                              input int rec);
        if (actual !== expected) begin
            $display("ERROR at %0t: record %0d addr_prediction is %h, expected %h",
                     $time, rec, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_csr(input logic [31:0] actual, input logic [31:0] expected,
                             input int rec);
        if (actual !== expected) begin
            $display("ERROR at %0t: record %0d csr_rdata is %h, expected %h",
                     $time, rec, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_record(input int rec);
        logic        want_jump;
        logic [31:0] want_addr;
        logic [31:0] want_rdata;
        want_jump  = model_jump();
        want_addr  = want_jump ? model_target[pc_in_if[NUM_BITS+1:2]] : pc4_in_if;
        want_rdata = model_read();
        if (exp_chk) begin
            if (exp_u_jump !== want_jump || exp_addr !== want_addr ||
                exp_rdata !== want_rdata) begin
                $display("Trace record %0d expects %0b %h %h but the model gives %0b %h %h",
                         rec, exp_u_jump, exp_addr, exp_rdata,
                         want_jump, want_addr, want_rdata);
                trace_errors++;
            end
            want_jump  = exp_u_jump;
            want_addr  = exp_addr;
            want_rdata = exp_rdata;
        end
        check_u_jump(u_jump, want_jump, rec);
        check_addr(addr_prediction, want_addr, rec);
        check_csr(csr_rdata, want_rdata, rec);
    endtask

    initial begin
        rst_n               = 1'b0;
        pc_in_if            = 32'd0;
        pc4_in_if           = 32'd4;
        ir_type_in_if       = '0;
        pc_in_ex            = 32'd0;
        ir_type_in_ex       = '0;
        jump_addr_if_taken  = 32'd0;
        is_prediction_wrong = 1'b0;
        csr_we              = 1'b0;
        csr_addr            = 2'd0;
        csr_wdata           = 32'd0;
        exp_chk             = 1'b0;
        load_trace();
        cycle_limit = RESET_CYCLES + trace_lines.size() + TIMEOUT_MARGIN;
        if (trace_lines.size() == 0) begin
            $display("No trace records were read, nothing to run");
            $display("Result: FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            model_reset();
            for (int r = 0; r < trace_lines.size(); r++) begin
                apply_record(trace_lines[r], r);
                #(CHECK_DELAY);
                check_record(r);
                model_step();
                @(posedge clk);
            end
            $display("Summary: %0d value errors, %0d trace errors, %0d format errors, %0d records",
                     value_errors, trace_errors, format_errors, trace_lines.size());
            if (value_errors + trace_errors + format_errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/bpu_top.sv */
`default_nettype none

module bpu_top
    import bpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,

    // IF stage
    input  wire [31:0]           pc_in_if,
    input  wire [31:0]           pc4_in_if,
    input  wire [IR_TYPE_W-1:0]  ir_type_in_if,
    output logic                 u_jump,
    output logic [31:0]          addr_prediction,

    // EX stage
    input  wire [31:0]           pc_in_ex,
    input  wire [IR_TYPE_W-1:0]  ir_type_in_ex,
    input  wire [31:0]           jump_addr_if_taken,
    input  wire                  is_prediction_wrong,

    // Register bus
    input  wire                  csr_we,
    input  wire [1:0]            csr_addr,
    input  wire [31:0]           csr_wdata,
    output logic [31:0]          csr_rdata
);

    logic enable;
    logic flush;
    logic lookup_strobe;
    logic mispredict_strobe;

    bpu_csr u_csr (
        .clk               (clk),
        .rst_n             (rst_n),
        .csr_we            (csr_we),
        .csr_addr          (csr_addr),
        .csr_wdata         (csr_wdata),
        .csr_rdata         (csr_rdata),
        .lookup_strobe     (lookup_strobe),
        .mispredict_strobe (mispredict_strobe),
        .enable            (enable),
        .flush             (flush)
    );

    jump_predictor u_predictor (
        .clk                 (clk),
        .rst_n               (rst_n),
        .enable              (enable),
        .flush               (flush),
        .pc_in_if            (pc_in_if),
        .pc4_in_if           (pc4_in_if),
        .ir_type_in_if       (ir_type_in_if),
        .pc_in_ex            (pc_in_ex),
        .ir_type_in_ex       (ir_type_in_ex),
        .jump_addr_if_taken  (jump_addr_if_taken),
        .is_prediction_wrong (is_prediction_wrong),
        .u_jump              (u_jump),
        .addr_prediction     (addr_prediction),
        .lookup_strobe       (lookup_strobe),
        .mispredict_strobe   (mispredict_strobe)
    );

endmodule

`default_nettype wire

/* rtl/bpu_csr.sv */
`default_nettype none

module bpu_csr
    import bpu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,

    // Register bus
    input  wire         csr_we,
    input  wire  [1:0]  csr_addr,
    input  wire  [31:0] csr_wdata,
    output logic [31:0] csr_rdata,

    // Events from the predictor
    input  wire         lookup_strobe,
    input  wire         mispredict_strobe,

    // Controls to the predictor
    output logic        enable,
    output logic        flush
);

    logic        wr_ctrl;
    logic        clr_lookups;
    logic        clr_mispredicts;
    logic [31:0] lookup_cnt;
    logic [31:0] mispredict_cnt;

    assign wr_ctrl         = csr_we && (csr_addr == CSR_CTRL);
    assign clr_lookups     = csr_we && (csr_addr == CSR_LOOKUPS);
    assign clr_mispredicts = csr_we && (csr_addr == CSR_MISPREDICTS);

    // Enable bit, comes up on after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b1;
        end else if (wr_ctrl) begin
            enable <= csr_wdata[CTRL_ENABLE_BIT];
        end
    end

    // Flush is a single pulse, a write during the pulse is absorbed by it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush <= 1'b0;
        end else begin
            flush <= wr_ctrl && csr_wdata[CTRL_FLUSH_BIT] && !flush;
        end
    end

    // Event counters, a bus write clears and wins over a strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_cnt <= '0;
        end else if (clr_lookups) begin
            lookup_cnt <= '0;
        end else if (lookup_strobe) begin
            lookup_cnt <= lookup_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mispredict_cnt <= '0;
        end else if (clr_mispredicts) begin
            mispredict_cnt <= '0;
        end else if (mispredict_strobe) begin
            mispredict_cnt <= mispredict_cnt + 32'd1;
        end
    end

    // Read mux, flush bit is write-only
    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            CSR_CTRL: begin
                csr_rdata[CTRL_ENABLE_BIT] = enable;
            end
            CSR_LOOKUPS: begin
                csr_rdata = lookup_cnt;
            end
            CSR_MISPREDICTS: begin
                csr_rdata = mispredict_cnt;
            end
            default: begin
                csr_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/jump_predictor.sv */
`default_nettype none

module jump_predictor
    import bpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,

    // From the register block
    input  wire                  enable,
    input  wire                  flush,

    // IF stage lookup
    input  wire [31:0]           pc_in_if,
    input  wire [31:0]           pc4_in_if,
    input  wire [IR_TYPE_W-1:0]  ir_type_in_if,

    // EX stage resolution
    input  wire [31:0]           pc_in_ex,
    input  wire [IR_TYPE_W-1:0]  ir_type_in_ex,
    input  wire [31:0]           jump_addr_if_taken,
    input  wire                  is_prediction_wrong,

    // Prediction back to IF
    output logic                 u_jump,
    output logic [31:0]          addr_prediction,

    // Event strobes for the counters
    output logic                 lookup_strobe,
    output logic                 mispredict_strobe
);

    // Counter states live in flops so they can be reset and flushed together
    logic [1:0]  state_q  [TABLE_SIZE];
    // Targets only matter once a state says take, no reset needed
    logic [31:0] target_q [TABLE_SIZE];

    logic                if_ctrl;
    logic [NUM_BITS-1:0] rd_idx;
    logic [1:0]          rd_state;
    logic [31:0]         rd_target;

    logic                ex_ctrl;
    logic [NUM_BITS-1:0] wr_idx;
    logic [1:0]          wr_state;

    function automatic logic is_ctrl_ir(input logic [IR_TYPE_W-1:0] ir_type);
        return (ir_type == JAL_IR) || (ir_type == JALR_IR) || (ir_type == BRANCH_IR);
    endfunction

    // Saturating update, a correct outcome always ends in a strong state
    function automatic logic [1:0] next_state(input logic [1:0] cur, input logic wrong);
        logic [1:0] nxt;
        if (!wrong) begin
            nxt = cur[1] ? STRONG_TAKE : STRONG_DONT_TAKE;
        end else begin
            case (cur)
                STRONG_DONT_TAKE: nxt = WEAK_DONT_TAKE;
                WEAK_DONT_TAKE:   nxt = WEAK_TAKE;
                WEAK_TAKE:        nxt = WEAK_DONT_TAKE;
                default:          nxt = WEAK_TAKE;
            endcase
        end
        return nxt;
    endfunction

    // Asynchronous lookup
    assign if_ctrl   = is_ctrl_ir(ir_type_in_if);
    assign rd_idx    = pc_in_if[NUM_BITS+1:2];
    assign rd_state  = state_q[rd_idx];
    assign rd_target = target_q[rd_idx];

    assign u_jump          = enable && if_ctrl && rd_state[1];
    assign addr_prediction = u_jump ? rd_target : pc4_in_if;

    // Update side
    assign ex_ctrl  = is_ctrl_ir(ir_type_in_ex);
    assign wr_idx   = pc_in_ex[NUM_BITS+1:2];
    assign wr_state = next_state(state_q[wr_idx], is_prediction_wrong);

    assign lookup_strobe     = enable && if_ctrl;
    assign mispredict_strobe = ex_ctrl && is_prediction_wrong;

    // Reset and flush both drop every entry back to weak-don't-take
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                state_q[i] <= WEAK_DONT_TAKE;
            end
        end else if (ex_ctrl) begin
            state_q[wr_idx] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ctrl && !flush) begin
            target_q[wr_idx] <= jump_addr_if_taken;
        end
    end

    // No entry predicts taken straight out of reset
    a_reset_clears_take: assert property (
        @(posedge clk)
        !rst_n |=> !u_jump
    );

    // Right after a flush no entry may predict taken yet
    a_flush_clears_take: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !u_jump
    );

endmodule

`default_nettype wire

/* rtl/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    // Instruction type code from the decode stage
    localparam int IR_TYPE_W = 4;

    // Control instruction classes, any other code is a plain instruction
    localparam logic [IR_TYPE_W-1:0] JAL_IR    = 4'd1;
    localparam logic [IR_TYPE_W-1:0] JALR_IR   = 4'd2;
    localparam logic [IR_TYPE_W-1:0] BRANCH_IR = 4'd3;

    // 2-bit saturating counter states
    // Upper bit set means the entry predicts taken
    localparam logic [1:0] STRONG_DONT_TAKE = 2'd0;
    localparam logic [1:0] WEAK_DONT_TAKE   = 2'd1;
    localparam logic [1:0] WEAK_TAKE        = 2'd2;
    localparam logic [1:0] STRONG_TAKE      = 2'd3;

    // Table sizing
    // Index comes from pc[NUM_BITS+1:2]
    localparam int NUM_BITS   = 5;
    localparam int TABLE_SIZE = 2 ** NUM_BITS;

    // Register block addresses, address 3 reads zero
    localparam logic [1:0] CSR_CTRL        = 2'd0;
    localparam logic [1:0] CSR_LOOKUPS     = 2'd1;
    localparam logic [1:0] CSR_MISPREDICTS = 2'd2;

    // Control register fields
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FLUSH_BIT  = 1;

endpackage

`default_nettype wire
